//--- hacd_settings.svh
//////////////////////////////////////////////////
// hacd settings
// address map, register offsets and noc flit fields
//////////////////////////////////////////////////
`ifndef HACD_SETTINGS_SVH
`define HACD_SETTINGS_SVH

// register window seen from the noc
`define HACD_BASE    32'hf510_0000
`define HACD_WIN     32'h0000_0020
`define NOC_DW       32

// register offsets, word aligned
`define REG_SRC_LO   5'h00
`define REG_SRC_HI   5'h04
`define REG_MASK     5'h08
`define REG_CTRL     5'h0c
`define REG_RES_LO   5'h10
`define REG_RES_HI   5'h14
// bit0 busy, bit1 inflate done, bit2 deflate done
`define REG_STATUS   5'h18

// header flit fields
`define NOC_OP_MSB   31
`define NOC_OP_LSB   29
`define NOC_SIZE_BIT 28
`define NOC_ERR_BIT  27

`endif

//--- hacd_pkg.sv
//////////////////////////////////////////////////
// hacd types
// opcodes and state encodings shared by the blocks
//////////////////////////////////////////////////
package hacd_pkg;

  // opcode in header flit bits 31:29
  typedef enum logic [2:0] {
    NOC_READ    = 3'b001,
    NOC_WRITE   = 3'b010,
    NOC_RD_RESP = 3'b011,
    NOC_WR_ACK  = 3'b100
  } noc_op_e;

  // value written to the control register
  typedef enum logic [1:0] {
    ENG_NONE    = 2'd0,
    ENG_DEFLATE = 2'd1,
    ENG_INFLATE = 2'd2
  } eng_op_e;

  // receive side and transmit side of the noc bridge
  typedef enum logic [3:0] {
    RX_HDR,
    RX_ADDR,
    RX_DATA_LO,
    RX_DATA_HI,
    RX_REQ,
    RX_REL,
    RX_WAIT,
    TX_IDLE,
    TX_HDR,
    TX_DATA_LO,
    TX_DATA_HI
  } bridge_state_e;

  // 64-bit to 32-bit splitter
  typedef enum logic [1:0] {
    IDLE,
    FIRST,
    SECOND,
    ACK
  } split_state_e;

endpackage

//--- hacd_noc_bridge.sv
//////////////////////////////////////////////////
// hacd noc bridge
// noc flits in and out, four-phase register request
//////////////////////////////////////////////////
`timescale 1ns/1ns
`include "hacd_settings.svh"

module hacd_noc_bridge (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic [`NOC_DW-1:0] noc2_data_i,
  input  logic              noc2_valid_i,
  output logic              noc2_ready_o,
  output logic [`NOC_DW-1:0] noc3_data_o,
  output logic              noc3_valid_o,
  input  logic              noc3_ready_i,
  output logic              sreq_o,
  output logic              swrite_o,
  output logic              ssize64_o,
  output logic [4:0]        soff_o,
  output logic [63:0]       swdata_o,
  input  logic              sack_i,
  input  logic [63:0]       srdata_i,
  input  logic              serr_i
);

  hacd_pkg::bridge_state_e rx_state_q, rx_state_d;
  hacd_pkg::bridge_state_e tx_state_q, tx_state_d;
  logic write_q, size64_q, err_q;
  logic [4:0] soff_q;
  logic [63:0] wdata_q, rdata_q;
  logic [31:0] addr_off;
  logic win_miss, rx_acc, tx_start, tx_last;
  logic [`NOC_DW-1:0] hdr;

  // ready only while collecting request flits
  assign noc2_ready_o = rx_state_q inside {hacd_pkg::RX_HDR, hacd_pkg::RX_ADDR,
                                           hacd_pkg::RX_DATA_LO, hacd_pkg::RX_DATA_HI};
  assign rx_acc = noc2_valid_i && noc2_ready_o;
  assign noc3_valid_o = tx_state_q inside {hacd_pkg::TX_HDR, hacd_pkg::TX_DATA_LO,
                                           hacd_pkg::TX_DATA_HI};

  // full offset kept for the miss check
  assign addr_off = noc2_data_i - `HACD_BASE;
  assign win_miss = addr_off >= `HACD_WIN;

  // four-phase master side
  assign sreq_o    = rx_state_q == hacd_pkg::RX_REQ;
  assign swrite_o  = write_q;
  assign ssize64_o = size64_q;
  assign soff_o    = soff_q;
  assign swdata_o  = wdata_q;

  // handshake fully closed, response may go out
  assign tx_start = rx_state_q == hacd_pkg::RX_REL && !sack_i;
  // last response flit taken by the noc
  assign tx_last = noc3_ready_i &&
                   (tx_state_q == hacd_pkg::TX_DATA_HI ||
                    (tx_state_q == hacd_pkg::TX_HDR && write_q) ||
                    (tx_state_q == hacd_pkg::TX_DATA_LO && !size64_q));

  //////////////////////////////////////////////////
  // receive fsm
  //////////////////////////////////////////////////
  always_comb begin
    rx_state_d = rx_state_q;
    unique case (rx_state_q)
      hacd_pkg::RX_HDR:     if (rx_acc) rx_state_d = hacd_pkg::RX_ADDR;
      hacd_pkg::RX_ADDR: begin
        if (rx_acc) rx_state_d = write_q ? hacd_pkg::RX_DATA_LO : hacd_pkg::RX_REQ;
      end
      hacd_pkg::RX_DATA_LO: begin
        if (rx_acc) rx_state_d = size64_q ? hacd_pkg::RX_DATA_HI : hacd_pkg::RX_REQ;
      end
      hacd_pkg::RX_DATA_HI: if (rx_acc) rx_state_d = hacd_pkg::RX_REQ;
      hacd_pkg::RX_REQ:     if (sack_i) rx_state_d = hacd_pkg::RX_REL;
      hacd_pkg::RX_REL:     if (!sack_i) rx_state_d = hacd_pkg::RX_WAIT;
      // noc2 stays stalled until the response is gone
      hacd_pkg::RX_WAIT:    if (tx_last) rx_state_d = hacd_pkg::RX_HDR;
      default:              rx_state_d = hacd_pkg::RX_HDR;
    endcase
  end

  //////////////////////////////////////////////////
  // transmit fsm
  //////////////////////////////////////////////////
  always_comb begin
    tx_state_d = tx_state_q;
    unique case (tx_state_q)
      hacd_pkg::TX_IDLE: if (tx_start) tx_state_d = hacd_pkg::TX_HDR;
      hacd_pkg::TX_HDR: begin
        if (noc3_ready_i) tx_state_d = write_q ? hacd_pkg::TX_IDLE : hacd_pkg::TX_DATA_LO;
      end
      hacd_pkg::TX_DATA_LO: begin
        if (noc3_ready_i) tx_state_d = size64_q ? hacd_pkg::TX_DATA_HI : hacd_pkg::TX_IDLE;
      end
      hacd_pkg::TX_DATA_HI: if (noc3_ready_i) tx_state_d = hacd_pkg::TX_IDLE;
      default:              tx_state_d = hacd_pkg::TX_IDLE;
    endcase
  end

  // response header, opcode follows the request kind
  always_comb begin
    hdr = '0;
    hdr[`NOC_OP_MSB:`NOC_OP_LSB] = write_q ? hacd_pkg::NOC_WR_ACK : hacd_pkg::NOC_RD_RESP;
    hdr[`NOC_SIZE_BIT] = size64_q;
    hdr[`NOC_ERR_BIT]  = err_q;
  end

  // low word first
  always_comb begin
    unique case (tx_state_q)
      hacd_pkg::TX_DATA_LO: noc3_data_o = rdata_q[31:0];
      hacd_pkg::TX_DATA_HI: noc3_data_o = rdata_q[63:32];
      default:              noc3_data_o = hdr;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rx_state_q <= hacd_pkg::RX_HDR;
      tx_state_q <= hacd_pkg::TX_IDLE;
      write_q    <= 1'b0;
      size64_q   <= 1'b0;
      err_q      <= 1'b0;
    end else begin
      rx_state_q <= rx_state_d;
      tx_state_q <= tx_state_d;
      if (rx_acc && rx_state_q == hacd_pkg::RX_HDR) begin
        write_q  <= hacd_pkg::noc_op_e'(noc2_data_i[`NOC_OP_MSB:`NOC_OP_LSB]) ==
                    hacd_pkg::NOC_WRITE;
        size64_q <= noc2_data_i[`NOC_SIZE_BIT];
      end
      if (rx_state_q == hacd_pkg::RX_REQ && sack_i) err_q <= serr_i;
    end
  end

  // request and response payload
  always_ff @(posedge clk_i) begin
    // a miss gets an offset the splitter rejects
    if (rx_acc && rx_state_q == hacd_pkg::RX_ADDR) soff_q <= win_miss ? 5'h1f : addr_off[4:0];
    if (rx_acc && rx_state_q == hacd_pkg::RX_DATA_LO) wdata_q[31:0] <= noc2_data_i;
    if (rx_acc && rx_state_q == hacd_pkg::RX_DATA_HI) wdata_q[63:32] <= noc2_data_i;
    if (rx_state_q == hacd_pkg::RX_REQ && sack_i) rdata_q <= srdata_i;
  end

  // stalled flit must not change
  a_noc3_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    noc3_valid_o && !noc3_ready_i |=> noc3_valid_o && $stable(noc3_data_o));

endmodule

//--- hacd_reg_split.sv
//////////////////////////////////////////////////
// hacd register splitter
// 64-bit requests become two 32-bit register strobes
//////////////////////////////////////////////////
`timescale 1ns/1ns
`include "hacd_settings.svh"

module hacd_reg_split (
  input  logic        clk_i,
  input  logic        arst_n_i,
  input  logic        sreq_i,
  input  logic        swrite_i,
  input  logic        ssize64_i,
  input  logic [4:0]  soff_i,
  input  logic [63:0] swdata_i,
  output logic        sack_o,
  output logic [63:0] srdata_o,
  output logic        serr_o,
  output logic        reg_valid_o,
  output logic        reg_write_o,
  output logic [4:0]  reg_addr_o,
  output logic [31:0] reg_wdata_o,
  input  logic [31:0] reg_rdata_i
);

  hacd_pkg::split_state_e state_q, state_d;
  logic [31:0] rword_q;
  logic [63:0] rdata_q;
  logic serr_q;
  logic [31:0] acc_end;
  logic bad;

  // first byte past the access
  assign acc_end = 32'(soff_i) + (ssize64_i ? 32'd8 : 32'd4);
  // past the window, or not aligned to its own size
  assign bad = acc_end > `HACD_WIN ||
               (ssize64_i ? soff_i[2:0] != 3'd0 : soff_i[1:0] != 2'd0);

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      hacd_pkg::IDLE: begin
        // errors skip the register strobes
        if (sreq_i) state_d = bad ? hacd_pkg::ACK : hacd_pkg::FIRST;
      end
      hacd_pkg::FIRST:  state_d = ssize64_i ? hacd_pkg::SECOND : hacd_pkg::ACK;
      hacd_pkg::SECOND: state_d = hacd_pkg::ACK;
      // hold ack until the master drops its request
      hacd_pkg::ACK:    if (!sreq_i) state_d = hacd_pkg::IDLE;
      default:          state_d = hacd_pkg::IDLE;
    endcase
  end

  // register strobe, low word then high word
  assign reg_valid_o = state_q == hacd_pkg::FIRST || state_q == hacd_pkg::SECOND;
  assign reg_write_o = reg_valid_o && swrite_i;
  assign reg_addr_o  = (state_q == hacd_pkg::SECOND) ? soff_i + 5'd4 : soff_i;
  assign reg_wdata_o = (state_q == hacd_pkg::SECOND) ? swdata_i[63:32] : swdata_i[31:0];

  assign sack_o   = state_q == hacd_pkg::ACK;
  assign srdata_o = rdata_q;
  assign serr_o   = serr_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= hacd_pkg::IDLE;
      serr_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q == hacd_pkg::IDLE && sreq_i) serr_q <= bad;
    end
  end

  // read data assembly, held through the ack phase
  always_ff @(posedge clk_i) begin
    if (state_q == hacd_pkg::IDLE && sreq_i && bad) rdata_q <= '0;
    if (state_q == hacd_pkg::FIRST) begin
      rword_q <= reg_rdata_i;
      // single word reads finish here
      if (!ssize64_i) rdata_q <= {32'h0, reg_rdata_i};
    end
    if (state_q == hacd_pkg::SECOND) rdata_q <= {reg_rdata_i, rword_q};
  end

  // ack never outlives the request by more than a cycle
  a_sack_window: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    sack_o |-> sreq_i || $past(sreq_i));

endmodule

//--- hacd_core.sv
//////////////////////////////////////////////////
// hacd core
// register file plus byte-serial deflate/inflate engine
//////////////////////////////////////////////////
`timescale 1ns/1ns
`include "hacd_settings.svh"

module hacd_core (
  input  logic        clk_i,
  input  logic        arst_n_i,
  input  logic        reg_valid_i,
  input  logic        reg_write_i,
  input  logic [4:0]  reg_addr_i,
  input  logic [31:0] reg_wdata_i,
  output logic [31:0] reg_rdata_o,
  output logic        infl_interrupt_o,
  output logic        defl_interrupt_o
);

  logic [63:0] src_q, res_q;
  logic [7:0] mask_q;
  hacd_pkg::eng_op_e op_q, op_wr;
  logic busy_q, infl_done_q, defl_done_q;
  // idx walks the unpacked side, pos the packed side
  logic [2:0] idx_q, pos_q;
  logic wr_en, start, take, last_step;
  logic [7:0] cur_byte, pk_byte;

  assign wr_en = reg_valid_i && reg_write_i;
  assign op_wr = hacd_pkg::eng_op_e'(reg_wdata_i[1:0]);
  // a start while busy is dropped
  assign start = wr_en && reg_addr_i == `REG_CTRL && !busy_q &&
                 (op_wr == hacd_pkg::ENG_DEFLATE || op_wr == hacd_pkg::ENG_INFLATE);

  assign cur_byte = src_q[{idx_q, 3'b000} +: 8];
  assign pk_byte  = src_q[{pos_q, 3'b000} +: 8];

  // deflate keeps nonzero bytes, inflate fills set mask bits
  assign take = busy_q && ((op_q == hacd_pkg::ENG_DEFLATE) ? cur_byte != 8'h00 : mask_q[idx_q]);
  assign last_step = busy_q && idx_q == 3'd7;

  assign infl_interrupt_o = infl_done_q;
  assign defl_interrupt_o = defl_done_q;

  //////////////////////////////////////////////////
  // register read mux
  //////////////////////////////////////////////////
  always_comb begin
    unique case (reg_addr_i)
      `REG_SRC_LO: reg_rdata_o = src_q[31:0];
      `REG_SRC_HI: reg_rdata_o = src_q[63:32];
      `REG_MASK:   reg_rdata_o = {24'h0, mask_q};
      `REG_CTRL:   reg_rdata_o = {30'h0, op_q};
      `REG_RES_LO: reg_rdata_o = res_q[31:0];
      `REG_RES_HI: reg_rdata_o = res_q[63:32];
      `REG_STATUS: reg_rdata_o = {29'h0, defl_done_q, infl_done_q, busy_q};
      // hole at 0x1c reads as zero
      default:     reg_rdata_o = 32'h0;
    endcase
  end

  //////////////////////////////////////////////////
  // engine control and status
  //////////////////////////////////////////////////
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q      <= 1'b0;
      op_q        <= hacd_pkg::ENG_NONE;
      idx_q       <= 3'd0;
      pos_q       <= 3'd0;
      infl_done_q <= 1'b0;
      defl_done_q <= 1'b0;
    end else begin
      if (start) begin
        busy_q <= 1'b1;
        op_q   <= op_wr;
        idx_q  <= 3'd0;
        pos_q  <= 3'd0;
      end else if (busy_q) begin
        // one byte per cycle, eight cycles total
        idx_q <= idx_q + 3'd1;
        if (take) pos_q <= pos_q + 3'd1;
        if (last_step) busy_q <= 1'b0;
      end
      // write one to clear the done bits
      if (wr_en && reg_addr_i == `REG_STATUS) begin
        if (reg_wdata_i[1]) infl_done_q <= 1'b0;
        if (reg_wdata_i[2]) defl_done_q <= 1'b0;
      end
      // completion wins over a clear in the same cycle
      if (last_step && op_q == hacd_pkg::ENG_INFLATE) infl_done_q <= 1'b1;
      if (last_step && op_q == hacd_pkg::ENG_DEFLATE) defl_done_q <= 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // data registers
  //////////////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    // source and mask locked while the engine runs
    if (wr_en && !busy_q) begin
      unique case (reg_addr_i)
        `REG_SRC_LO: src_q[31:0]  <= reg_wdata_i;
        `REG_SRC_HI: src_q[63:32] <= reg_wdata_i;
        `REG_MASK:   mask_q       <= reg_wdata_i[7:0];
        default: ;
      endcase
    end
    if (start) begin
      // result starts empty so unused bytes read zero
      res_q <= '0;
      if (op_wr == hacd_pkg::ENG_DEFLATE) mask_q <= '0;
    end else if (take) begin
      if (op_q == hacd_pkg::ENG_DEFLATE) begin
        // append at the next free packed byte
        res_q[{pos_q, 3'b000} +: 8] <= cur_byte;
        mask_q[idx_q] <= 1'b1;
      end else begin
        // next packed byte goes to this position
        res_q[{idx_q, 3'b000} +: 8] <= pk_byte;
      end
    end
  end

  // the splitter only issues word accesses
  a_word_aligned: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    reg_valid_i |-> reg_addr_i[1:0] == 2'b00);

endmodule

//--- hacd_top.sv
//////////////////////////////////////////////////
// hacd top
// noc bridge, register splitter and core
//////////////////////////////////////////////////
`timescale 1ns/1ns
`include "hacd_settings.svh"

module hacd_top (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic [`NOC_DW-1:0] noc2_data_i,
  input  logic               noc2_valid_i,
  output logic               noc2_ready_o,
  output logic [`NOC_DW-1:0] noc3_data_o,
  output logic               noc3_valid_o,
  input  logic               noc3_ready_i,
  output logic               infl_interrupt_o,
  output logic               defl_interrupt_o
);

  // bridge to splitter, four-phase
  logic        sreq, swrite, ssize64, sack, serr;
  logic [4:0]  soff;
  logic [63:0] swdata, srdata;

  // splitter to core, single-cycle strobe
  logic        reg_valid, reg_write;
  logic [4:0]  reg_addr;
  logic [31:0] reg_wdata, reg_rdata;

  hacd_noc_bridge i_bridge (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .noc2_data_i  (noc2_data_i),
    .noc2_valid_i (noc2_valid_i),
    .noc2_ready_o (noc2_ready_o),
    .noc3_data_o  (noc3_data_o),
    .noc3_valid_o (noc3_valid_o),
    .noc3_ready_i (noc3_ready_i),
    .sreq_o       (sreq),
    .swrite_o     (swrite),
    .ssize64_o    (ssize64),
    .soff_o       (soff),
    .swdata_o     (swdata),
    .sack_i       (sack),
    .srdata_i     (srdata),
    .serr_i       (serr)
  );

  hacd_reg_split i_split (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .sreq_i      (sreq),
    .swrite_i    (swrite),
    .ssize64_i   (ssize64),
    .soff_i      (soff),
    .swdata_i    (swdata),
    .sack_o      (sack),
    .srdata_o    (srdata),
    .serr_o      (serr),
    .reg_valid_o (reg_valid),
    .reg_write_o (reg_write),
    .reg_addr_o  (reg_addr),
    .reg_wdata_o (reg_wdata),
    .reg_rdata_i (reg_rdata)
  );

  hacd_core i_core (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .reg_valid_i      (reg_valid),
    .reg_write_i      (reg_write),
    .reg_addr_i       (reg_addr),
    .reg_wdata_i      (reg_wdata),
    .reg_rdata_o      (reg_rdata),
    .infl_interrupt_o (infl_interrupt_o),
    .defl_interrupt_o (defl_interrupt_o)
  );

endmodule

//--- tb_hacd_top.sv
//////////////////////////////////////////////////
// hacd testbench
// replays the test data over the noc ports and checks replies
//////////////////////////////////////////////////
`timescale 1ns/1ns
`include "hacd_settings.svh"

module tb_hacd_top;

  // per-flit wait limit and status poll limit
  localparam int RESP_LIMIT = 200;
  localparam int POLL_LIMIT = 20;

  logic               clk_i = 1'b0;
  logic               arst_n_i;
  logic [`NOC_DW-1:0] noc2_data_i;
  logic               noc2_valid_i;
  logic               noc2_ready_o;
  logic [`NOC_DW-1:0] noc3_data_o;
  logic               noc3_valid_o;
  logic               noc3_ready_i;
  logic               infl_interrupt_o;
  logic               defl_interrupt_o;

  int    seed = 32'hfa843cc3;
  string recs[$];
  bit    loaded = 1'b0;
  string test_name = "none";

  hacd_top i_dut (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .noc2_data_i      (noc2_data_i),
    .noc2_valid_i     (noc2_valid_i),
    .noc2_ready_o     (noc2_ready_o),
    .noc3_data_o      (noc3_data_o),
    .noc3_valid_o     (noc3_valid_o),
    .noc3_ready_i     (noc3_ready_i),
    .infl_interrupt_o (infl_interrupt_o),
    .defl_interrupt_o (defl_interrupt_o)
  );

  // 4 ns period
  always #2 clk_i = ~clk_i;

  //////////////////////////////////////////////////
  // reporting
  //////////////////////////////////////////////////
  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1, "stopping on first failure");
  endtask

  task automatic check_value(input string name, input logic [63:0] exp_v,
                             input logic [63:0] act_v);
    if (act_v !== exp_v) begin
      stop_run($sformatf("[ERROR] %s: expected %h, actual %h", name, exp_v, act_v));
    end
  endtask

  task automatic require_fields(input int got, input int want, input string rec);
    if (got != want) stop_run($sformatf("malformed test data line: %s", rec));
  endtask

  // window and alignment rule, offset taken from the base
  function automatic bit expect_error(input bit is64, input logic [31:0] addr);
    logic [31:0] off;
    off = addr - `HACD_BASE;
    return off >= `HACD_WIN || (is64 && off[2:0] != 3'd0);
  endfunction

  //////////////////////////////////////////////////
  // noc flit level
  //////////////////////////////////////////////////
  // entered just after a rising edge, leaves just after the edge that took the flit
  task automatic send_flit(input logic [31:0] flit);
    int waited;
    waited = 0;
    noc2_data_i  <= flit;
    noc2_valid_i <= 1'b1;
    @(negedge clk_i);
    while (!noc2_ready_o) begin
      waited++;
      if (waited > RESP_LIMIT) stop_run("DUT never became ready for a request flit");
      @(negedge clk_i);
    end
    @(posedge clk_i);
  endtask

  // random back-pressure, one draw per cycle
  task automatic recv_flit(output logic [31:0] flit);
    int waited;
    int draw;
    bit taken;
    waited = 0;
    taken  = 1'b0;
    flit   = '0;
    while (!taken) begin
      @(posedge clk_i);
      draw = $random(seed);
      noc3_ready_i <= draw[0];
      @(negedge clk_i);
      if (noc3_valid_o && noc3_ready_i) begin
        flit  = noc3_data_o;
        taken = 1'b1;
      end else begin
        waited++;
        if (waited > RESP_LIMIT) stop_run("no response flit came back from the DUT");
      end
    end
  endtask

  // one request and its whole response
  task automatic noc_access(input bit is_write, input bit is64, input logic [31:0] addr,
                            input logic [63:0] wdata, output logic [63:0] rdata,
                            output bit err);
    logic [31:0] hdr, lo, hi;
    hdr = '0;
    hdr[`NOC_OP_MSB:`NOC_OP_LSB] = is_write ? hacd_pkg::NOC_WRITE : hacd_pkg::NOC_READ;
    hdr[`NOC_SIZE_BIT] = is64;
    lo = '0;
    hi = '0;
    @(posedge clk_i);
    send_flit(hdr);
    send_flit(addr);
    if (is_write) begin
      send_flit(wdata[31:0]);
      if (is64) send_flit(wdata[63:32]);
    end
    noc2_valid_i <= 1'b0;
    recv_flit(hdr);
    check_value({test_name, " response opcode"},
                64'(is_write ? hacd_pkg::NOC_WR_ACK : hacd_pkg::NOC_RD_RESP),
                64'(hdr[`NOC_OP_MSB:`NOC_OP_LSB]));
    err = hdr[`NOC_ERR_BIT];
    // read data follows the header, low word first
    if (!is_write) begin
      recv_flit(lo);
      if (is64) recv_flit(hi);
    end
    rdata = {hi, lo};
    // edge that takes the last flit
    @(posedge clk_i);
    noc3_ready_i <= 1'b0;
  endtask

  //////////////////////////////////////////////////
  // test data records
  //////////////////////////////////////////////////
  task automatic run_record(input string rec);
    byte         cmd;
    string       rest;
    logic [63:0] f_a, f_b, f_c, f_d;
    logic [63:0] rdata;
    bit          err, done_seen;
    int          n, polls;
    cmd  = rec.getc(0);
    rest = rec.substr(1, rec.len() - 1);
    case (cmd)
      "N": begin
        n = $sscanf(rest, "%s", test_name);
        require_fields(n, 1, rec);
      end
      "W": begin
        n = $sscanf(rest, "%h %h %h", f_a, f_b, f_c);
        require_fields(n, 3, rec);
        noc_access(1'b1, f_a == 64'h8, f_b[31:0], f_c, rdata, err);
        check_value({test_name, " write error bit"},
                    64'(expect_error(f_a == 64'h8, f_b[31:0])), 64'(err));
      end
      "R": begin
        n = $sscanf(rest, "%h %h %h %h", f_a, f_b, f_c, f_d);
        require_fields(n, 4, rec);
        noc_access(1'b0, f_a == 64'h8, f_b[31:0], 64'h0, rdata, err);
        check_value({test_name, " read error bit"}, f_d, 64'(err));
        if (!f_d[0]) check_value({test_name, " read data"}, f_c, rdata);
      end
      "P": begin
        n = $sscanf(rest, "%h %h", f_a, f_b);
        require_fields(n, 2, rec);
        polls     = 0;
        done_seen = 1'b0;
        // 32-bit status reads until all wanted bits are set
        while (!done_seen) begin
          if (polls == POLL_LIMIT) begin
            stop_run($sformatf("%s: status bits %h never set", test_name, f_b));
          end
          noc_access(1'b0, 1'b0, f_a[31:0], 64'h0, rdata, err);
          check_value({test_name, " poll error bit"}, 64'h0, 64'(err));
          done_seen = (rdata & f_b) == f_b;
          polls++;
        end
      end
      "I": begin
        n = $sscanf(rest, "%h %h", f_a, f_b);
        require_fields(n, 2, rec);
        @(negedge clk_i);
        check_value({test_name, " inflate interrupt"}, f_a, 64'(infl_interrupt_o));
        check_value({test_name, " deflate interrupt"}, f_b, 64'(defl_interrupt_o));
      end
      default: stop_run($sformatf("unknown command in test data: %s", rec));
    endcase
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////
  initial begin
    int    fd;
    string line;
    arst_n_i     = 1'b0;
    noc2_data_i  = '0;
    noc2_valid_i = 1'b0;
    noc3_ready_i = 1'b0;
    fd = $fopen("hacd_testdata.txt", "r");
    if (fd == 0) stop_run("could not open hacd_testdata.txt");
    // blank and # lines carry no record
    while ($fgets(line, fd) != 0) begin
      if (line.len() > 1 && line.getc(0) != "#") recs.push_back(line);
    end
    $fclose(fd);
    loaded = 1'b1;
    repeat (3) @(posedge clk_i);
    arst_n_i <= 1'b1;
    @(negedge clk_i);
    check_value("reset noc2 ready", 64'h1, 64'(noc2_ready_o));
    check_value("reset noc3 valid", 64'h0, 64'(noc3_valid_o));
    foreach (recs[i]) run_record(recs[i]);
    $display("Simulation completed successfully");
    $finish;
  end

  // 300 cycles of budget per record
  initial begin
    longint unsigned watchdog_ns;
    wait (loaded);
    watchdog_ns = 64'(recs.size()) * 64'd300 * 64'd4;
    #(watchdog_ns);
    stop_run($sformatf("timeout: test data not finished after %0d ns", watchdog_ns));
  end

endmodule

//--- hacd_testdata.txt
# cmd and hex fields: W size addr data | R size addr exp_data exp_err
# P addr status_bits (poll until set) | I exp_infl exp_defl | N test_name
N reg_round_trip
W 8 f5100000 0011223344556677
R 8 f5100000 0011223344556677 0
R 4 f5100004 00112233 0
W 4 f5100008 0000a5c3
R 4 f5100008 c3 0
N deflate
W 8 f5100000 00ab00cdef000012
W 4 f510000c 1
P f5100018 4
R 8 f5100010 00000000abcdef12 0
R 4 f5100008 59 0
I 0 1
W 4 f5100018 4
I 0 0
N inflate
W 8 f5100000 00000000abcdef12
W 4 f5100008 59
W 4 f510000c 2
P f5100018 2
R 8 f5100010 00ab00cdef000012 0
I 1 0
W 4 f5100018 2
I 0 0
R 4 f5100018 0 0
N error_response
R 4 f5100020 0 1
R 8 f50ffff8 0 1
W 4 f5100040 deadbeef
W 8 f5100004 1111111122222222
R 8 f5100014 0 1
R 8 f5100000 00000000abcdef12 0
N backpressure_64
W 8 f5100000 8899aabbccddeeff
R 8 f5100000 8899aabbccddeeff 0
R 8 f5100010 00ab00cdef000012 0
R 8 f5100000 8899aabbccddeeff 0
R 8 f5100010 00ab00cdef000012 0

//--- flist.f
+incdir+.
hacd_pkg.sv
hacd_noc_bridge.sv
hacd_reg_split.sv
hacd_core.sv
hacd_top.sv
tb_hacd_top.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_hacd_top
FLIST     = flist.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
